// ==== source/huffman_pkg.sv ====
package huffman_pkg;

	localparam int sym_count    = 6;
	localparam int merge_rounds = sym_count - 1;

	typedef logic [7:0] count_t;
	typedef logic [7:0] mask_t; // bit k is symbol k+1
	typedef logic [7:0] code_t;
	typedef logic [7:0] gray_t;
	typedef logic [2:0] step_t;

	typedef enum logic [2:0] {
		phase_idle,
		phase_receive,
		phase_count_out,
		phase_load,
		phase_merge,
		phase_split,
		phase_code_out,
		phase_done
	} phase_e;

	typedef struct packed {
		count_t count;
		mask_t  mask;
	} node_t;

	// a ranks below b: smaller count, on a tie the larger mask
	function automatic logic node_below(node_t a, node_t b);
		return (a.count < b.count) || ((a.count == b.count) && (a.mask > b.mask));
	endfunction

endpackage

// ==== source/symbol_histogram.sv ====
`timescale 1ns/1ns

module symbol_histogram (
	input  logic                clk,
	input  logic                reset,
	input  logic                gray_valid,
	input  huffman_pkg::gray_t  gray_data,
	output huffman_pkg::count_t cnt1,
	output huffman_pkg::count_t cnt2,
	output huffman_pkg::count_t cnt3,
	output huffman_pkg::count_t cnt4,
	output huffman_pkg::count_t cnt5,
	output huffman_pkg::count_t cnt6
);
	import huffman_pkg::*;

	count_t cnt_q [sym_count];

	// one counter per gray value, 8 bit wrap
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < sym_count; k++)
				cnt_q[k] <= '0;
		end else if (gray_valid) begin
			for (int k = 0; k < sym_count; k++)
				if (gray_data == gray_t'(k + 1))
					cnt_q[k] <= cnt_q[k] + count_t'(1);
		end
	end

	assign cnt1 = cnt_q[0];
	assign cnt2 = cnt_q[1];
	assign cnt3 = cnt_q[2];
	assign cnt4 = cnt_q[3];
	assign cnt5 = cnt_q[4];
	assign cnt6 = cnt_q[5];

endmodule

// ==== source/huffman_control.sv ====
`timescale 1ns/1ns

module huffman_control (
	input  logic                clk,
	input  logic                reset,
	input  logic                gray_valid,
	output huffman_pkg::phase_e phase,
	output huffman_pkg::step_t  step,
	output logic                cnt_valid,
	output logic                code_valid
);
	import huffman_pkg::*;

	phase_e phase_next;
	step_t  step_next;
	logic   last_step;

	// ====================
	// phase lengths
	always_comb begin
		case (phase)
			phase_load:
				last_step = (step == step_t'(sym_count - 1));
			phase_merge, phase_split:
				last_step = (step == step_t'(merge_rounds - 1));
			default:
				last_step = 1'b1; // single cycle phases
		endcase
	end

	// ====================
	// next phase
	always_comb begin
		case (phase)
			phase_idle:      phase_next = gray_valid ? phase_receive : phase_idle;
			phase_receive:   phase_next = gray_valid ? phase_receive : phase_count_out;
			phase_count_out: phase_next = phase_load;
			phase_load:      phase_next = last_step ? phase_merge : phase_load;
			phase_merge:     phase_next = last_step ? phase_split : phase_merge;
			phase_split:     phase_next = last_step ? phase_code_out : phase_split;
			phase_code_out:  phase_next = phase_done;
			default:         phase_next = phase_done; // stays until reset
		endcase
	end

	// step restarts at 0 on every phase change
	assign step_next = (phase_next == phase && !last_step) ? step + step_t'(1) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase      <= phase_idle;
			step       <= '0;
			cnt_valid  <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			phase      <= phase_next;
			step       <= step_next;
			cnt_valid  <= (phase_next == phase_count_out);
			code_valid <= (phase_next == phase_code_out);
		end
	end

endmodule

// ==== source/node_list.sv ====
`timescale 1ns/1ns

module node_list (
	input  logic                clk,
	input  logic                reset,
	input  huffman_pkg::phase_e phase,
	input  huffman_pkg::step_t  step,
	input  huffman_pkg::count_t cnt1,
	input  huffman_pkg::count_t cnt2,
	input  huffman_pkg::count_t cnt3,
	input  huffman_pkg::count_t cnt4,
	input  huffman_pkg::count_t cnt5,
	input  huffman_pkg::count_t cnt6,
	output huffman_pkg::mask_t  low_mask,
	output huffman_pkg::mask_t  high_mask
);
	import huffman_pkg::*;

	node_t                slot_q [sym_count]; // slot 0 ranks lowest
	logic [sym_count-1:0] valid_q;
	node_t                base [sym_count];
	logic [sym_count-1:0] base_v;
	node_t                base_up [sym_count];
	node_t                slot_d [sym_count];
	logic [sym_count-1:0] valid_d;
	logic [sym_count-1:0] below;
	logic [sym_count-1:0] prev_below;
	count_t               cnts [sym_count];
	node_t                in_node;
	logic                 insert_en;

	assign cnts      = '{cnt1, cnt2, cnt3, cnt4, cnt5, cnt6};
	assign insert_en = (phase == phase_load) || (phase == phase_merge);

	// ====================
	// list before insertion and the incoming node
	always_comb begin
		base   = slot_q;
		base_v = valid_q;
		if (phase == phase_merge) begin
			// drop the two lowest nodes
			for (int i = 0; i < sym_count - 2; i++)
				base[i] = slot_q[i + 2];
			base_v = valid_q >> 2;
			in_node.count = slot_q[0].count + slot_q[1].count;
			in_node.mask  = slot_q[0].mask | slot_q[1].mask;
		end else begin
			in_node.count = cnts[step];
			in_node.mask  = mask_t'(1) << step; // one-hot leaf
		end
	end

	// ====================
	// parallel insertion, each slot holds, shifts up or takes the new node
	always_comb begin
		for (int i = 0; i < sym_count; i++)
			below[i] = base_v[i] && node_below(base[i], in_node);
		prev_below = {below[sym_count-2:0], 1'b1};
		base_up[0] = in_node;
		for (int i = 1; i < sym_count; i++)
			base_up[i] = base[i - 1];
		for (int i = 0; i < sym_count; i++) begin
			if (below[i]) begin
				slot_d[i]  = base[i];
				valid_d[i] = base_v[i];
			end else if (prev_below[i]) begin
				slot_d[i]  = in_node;
				valid_d[i] = 1'b1;
			end else begin
				slot_d[i]  = base_up[i];
				valid_d[i] = base_v[i - 1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			valid_q <= '0;
		else if (insert_en)
			valid_q <= valid_d;
	end

	always_ff @(posedge clk) begin
		if (insert_en)
			slot_q <= slot_d;
	end

	assign low_mask  = slot_q[0].mask;
	assign high_mask = slot_q[1].mask;

endmodule

// ==== source/code_builder.sv ====
`timescale 1ns/1ns

module code_builder (
	input  logic                clk,
	input  logic                reset,
	input  huffman_pkg::phase_e phase,
	input  huffman_pkg::step_t  step,
	input  huffman_pkg::mask_t  low_mask,
	input  huffman_pkg::mask_t  high_mask,
	output huffman_pkg::code_t  hc1,
	output huffman_pkg::code_t  hc2,
	output huffman_pkg::code_t  hc3,
	output huffman_pkg::code_t  hc4,
	output huffman_pkg::code_t  hc5,
	output huffman_pkg::code_t  hc6,
	output huffman_pkg::code_t  m1,
	output huffman_pkg::code_t  m2,
	output huffman_pkg::code_t  m3,
	output huffman_pkg::code_t  m4,
	output huffman_pkg::code_t  m5,
	output huffman_pkg::code_t  m6
);
	import huffman_pkg::*;

	mask_t log_low  [merge_rounds];
	mask_t log_high [merge_rounds];
	step_t rd_idx;
	mask_t rd_low;
	mask_t rd_high;
	code_t hc_q [sym_count];
	code_t m_q  [sym_count];

	// split walks the merge log from the root down
	assign rd_idx  = step_t'(merge_rounds - 1) - step;
	assign rd_low  = log_low[rd_idx];
	assign rd_high = log_high[rd_idx];

	always_ff @(posedge clk) begin
		if (phase == phase_merge) begin
			log_low[step]  <= low_mask;
			log_high[step] <= high_mask;
		end
	end

	// ====================
	// per-symbol shift registers
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < sym_count; k++) begin
				hc_q[k] <= '0;
				m_q[k]  <= '0;
			end
		end else if (phase == phase_split) begin
			for (int k = 0; k < sym_count; k++) begin
				if (rd_low[k]) begin
					hc_q[k] <= {hc_q[k][6:0], 1'b1}; // lower node gets the 1
					m_q[k]  <= {m_q[k][6:0], 1'b1};
				end else if (rd_high[k]) begin
					hc_q[k] <= {hc_q[k][6:0], 1'b0};
					m_q[k]  <= {m_q[k][6:0], 1'b1};
				end
			end
		end
	end

	assign hc1 = hc_q[0];
	assign hc2 = hc_q[1];
	assign hc3 = hc_q[2];
	assign hc4 = hc_q[3];
	assign hc5 = hc_q[4];
	assign hc6 = hc_q[5];
	assign m1  = m_q[0];
	assign m2  = m_q[1];
	assign m3  = m_q[2];
	assign m4  = m_q[3];
	assign m5  = m_q[4];
	assign m6  = m_q[5];

endmodule

// ==== source/huffman.sv ====
`timescale 1ns/1ns

module huffman (
	input  logic                clk,
	input  logic                reset,
	input  logic                gray_valid,
	input  huffman_pkg::gray_t  gray_data,
	output logic                CNT_valid,
	output huffman_pkg::count_t CNT1,
	output huffman_pkg::count_t CNT2,
	output huffman_pkg::count_t CNT3,
	output huffman_pkg::count_t CNT4,
	output huffman_pkg::count_t CNT5,
	output huffman_pkg::count_t CNT6,
	output logic                code_valid,
	output huffman_pkg::code_t  HC1,
	output huffman_pkg::code_t  HC2,
	output huffman_pkg::code_t  HC3,
	output huffman_pkg::code_t  HC4,
	output huffman_pkg::code_t  HC5,
	output huffman_pkg::code_t  HC6,
	output huffman_pkg::code_t  M1,
	output huffman_pkg::code_t  M2,
	output huffman_pkg::code_t  M3,
	output huffman_pkg::code_t  M4,
	output huffman_pkg::code_t  M5,
	output huffman_pkg::code_t  M6
);
	import huffman_pkg::*;

	phase_e phase;
	step_t  step;
	mask_t  low_mask;  // two lowest nodes of the current merge
	mask_t  high_mask;

	symbol_histogram u_histogram (
		.clk(clk), .reset(reset), .gray_valid(gray_valid), .gray_data(gray_data),
		.cnt1(CNT1), .cnt2(CNT2), .cnt3(CNT3), .cnt4(CNT4), .cnt5(CNT5), .cnt6(CNT6)
	);

	huffman_control u_control (
		.clk(clk), .reset(reset), .gray_valid(gray_valid), .phase(phase), .step(step),
		.cnt_valid(CNT_valid), .code_valid(code_valid)
	);

	node_list u_nodes (
		.clk(clk), .reset(reset), .phase(phase), .step(step),
		.cnt1(CNT1), .cnt2(CNT2), .cnt3(CNT3), .cnt4(CNT4), .cnt5(CNT5), .cnt6(CNT6),
		.low_mask(low_mask), .high_mask(high_mask)
	);

	code_builder u_codes (
		.clk(clk), .reset(reset), .phase(phase), .step(step),
		.low_mask(low_mask), .high_mask(high_mask),
		.hc1(HC1), .hc2(HC2), .hc3(HC3), .hc4(HC4), .hc5(HC5), .hc6(HC6),
		.m1(M1), .m2(M2), .m3(M3), .m4(M4), .m5(M5), .m6(M6)
	);

endmodule

// ==== tests/huffman_assertions.sv ====
`timescale 1ns/1ns

module huffman_assertions (
	input logic               clk,
	input logic               reset,
	input logic               CNT_valid,
	input logic               code_valid,
	input huffman_pkg::code_t HC1, HC2, HC3, HC4, HC5, HC6,
	input huffman_pkg::code_t M1, M2, M3, M4, M5, M6
);
	import huffman_pkg::*;

	code_t hc_all [sym_count];
	code_t m_all [sym_count];
	logic  cnt_seen;
	bit    fired = 1'b0;

	assign hc_all = '{HC1, HC2, HC3, HC4, HC5, HC6};
	assign m_all  = '{M1, M2, M3, M4, M5, M6};

	always_ff @(posedge clk) begin
		if (reset)
			cnt_seen <= 1'b0;
		else if (CNT_valid)
			cnt_seen <= 1'b1;
	end

	// ====================
	// pulse shape
	cnt_single: assert property (@(posedge clk) disable iff (reset) CNT_valid |=> !CNT_valid)
		else begin $error("CNT_valid stayed high for more than one cycle"); fired = 1'b1; end

	code_single: assert property (@(posedge clk) disable iff (reset) code_valid |=> !code_valid)
		else begin $error("code_valid stayed high for more than one cycle"); fired = 1'b1; end

	code_after_cnt: assert property (@(posedge clk) disable iff (reset) code_valid |-> cnt_seen)
		else begin $error("code_valid came without an earlier CNT_valid"); fired = 1'b1; end

	quiet_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !CNT_valid && !code_valid)
		else begin $error("a valid pulse was high during reset"); fired = 1'b1; end

	// length mask is a run of ones from bit 0, code bits only inside it
	for (genvar k = 0; k < sym_count; k++) begin : g_code
		code_shape: assert property (@(posedge clk) disable iff (reset)
			code_valid |-> (m_all[k] != '0) && ((m_all[k] & (m_all[k] + code_t'(1))) == '0)
				&& ((hc_all[k] & ~m_all[k]) == '0))
			else begin $error("code word or length mask of a symbol is malformed"); fired = 1'b1; end
	end

endmodule

bind huffman huffman_assertions u_assertions (.*);

// ==== tests/huffman_tb.sv ====
`timescale 1ns/1ns

module huffman_tb;
	import huffman_pkg::*;

	localparam int case_count  = 9;
	localparam int max_len     = 200;
	localparam int period_ns   = 4;
	localparam int watchdog_ns = case_count * (max_len + 40) * period_ns;

	logic   clk = 1'b0;
	logic   reset;
	logic   gray_valid;
	gray_t  gray_data;
	logic   CNT_valid;
	logic   code_valid;
	count_t cnt_o [sym_count];
	code_t  hc_o [sym_count];
	code_t  m_o [sym_count];

	integer seed = 32'h20f8;
	gray_t  stream [$];
	int     exp_cnt [sym_count];
	code_t  exp_hc [sym_count];
	code_t  exp_m [sym_count];
	int     cnt_pulses;
	int     code_pulses;

	always #2 clk = ~clk; // 4 ns period

	huffman uut (
		.clk(clk), .reset(reset), .gray_valid(gray_valid), .gray_data(gray_data),
		.CNT_valid(CNT_valid), .code_valid(code_valid),
		.CNT1(cnt_o[0]), .CNT2(cnt_o[1]), .CNT3(cnt_o[2]),
		.CNT4(cnt_o[3]), .CNT5(cnt_o[4]), .CNT6(cnt_o[5]),
		.HC1(hc_o[0]), .HC2(hc_o[1]), .HC3(hc_o[2]),
		.HC4(hc_o[3]), .HC5(hc_o[4]), .HC6(hc_o[5]),
		.M1(m_o[0]), .M2(m_o[1]), .M3(m_o[2]),
		.M4(m_o[3]), .M5(m_o[4]), .M6(m_o[5])
	);

	task automatic abort_run(string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(string what);
		abort_run($sformatf("MISMATCH at %0t ns: %s", $time, what));
	endtask

	function automatic int draw(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// ====================
	// stimulus builders
	task automatic random_stream(int len, int span);
		stream.delete();
		repeat (len)
			stream.push_back(gray_t'(draw(span))); // 0 and anything above 6 is out of range
	endtask

	task automatic stream_from_counts(int c [sym_count]);
		int    j;
		gray_t t;
		stream.delete();
		for (int k = 0; k < sym_count; k++)
			repeat (c[k]) stream.push_back(gray_t'(k + 1));
		for (int i = stream.size() - 1; i > 0; i--) begin
			j = draw(i + 1);
			t = stream[i];
			stream[i] = stream[j];
			stream[j] = t;
		end
	endtask

	task automatic distinct_counts();
		int c [sym_count];
		bit clash;
		for (int k = 0; k < sym_count; k++) begin
			do begin
				c[k] = 1 + draw(30);
				clash = 1'b0;
				for (int i = 0; i < k; i++)
					if (c[i] == c[k]) clash = 1'b1;
			end while (clash);
		end
		stream_from_counts(c);
	endtask

	// ====================
	// reference Huffman model
	function automatic bit ranks_lower(int ca, int ma, int cb, int mb);
		return (ca < cb) || (ca == cb && ma > mb);
	endfunction

	task automatic build_reference();
		int node_cnt [sym_count];
		int node_msk [sym_count];
		bit live [sym_count];
		int rnd_low [merge_rounds];
		int rnd_high [merge_rounds];
		int lo;
		int hi;
		foreach (exp_cnt[k]) exp_cnt[k] = 0;
		foreach (stream[i])
			if (stream[i] >= 1 && stream[i] <= sym_count) exp_cnt[stream[i] - 1]++;
		for (int k = 0; k < sym_count; k++) begin
			node_cnt[k] = exp_cnt[k];
			node_msk[k] = 1 << k;
			live[k]     = 1'b1;
			exp_hc[k]   = '0;
			exp_m[k]    = '0;
		end
		for (int r = 0; r < merge_rounds; r++) begin
			lo = -1;
			hi = -1;
			for (int k = 0; k < sym_count; k++)
				if (live[k] && (lo < 0 || ranks_lower(node_cnt[k], node_msk[k],
						node_cnt[lo], node_msk[lo]))) lo = k;
			for (int k = 0; k < sym_count; k++)
				if (live[k] && k != lo && (hi < 0 || ranks_lower(node_cnt[k], node_msk[k],
						node_cnt[hi], node_msk[hi]))) hi = k;
			rnd_low[r]  = node_msk[lo];
			rnd_high[r] = node_msk[hi];
			node_cnt[lo] += node_cnt[hi]; // merged node kept in the low entry
			node_msk[lo] |= node_msk[hi];
			live[hi] = 1'b0;
		end
		// codes grow root first and the lower node of a merge gets a 1
		for (int r = merge_rounds - 1; r >= 0; r--)
			for (int k = 0; k < sym_count; k++)
				if (rnd_low[r][k] || rnd_high[r][k]) begin
					exp_hc[k] = (exp_hc[k] << 1) | code_t'(rnd_low[r][k]);
					exp_m[k]  = (exp_m[k] << 1) | code_t'(1);
				end
	endtask

	// ====================
	// checks
	task automatic check_counts(string label);
		for (int k = 0; k < sym_count; k++)
			assert (cnt_o[k] == count_t'(exp_cnt[k])) else report_mismatch($sformatf(
				"%s: CNT%0d is %0d, expected %0d", label, k + 1, cnt_o[k], exp_cnt[k]));
	endtask

	task automatic check_codes(string label);
		for (int k = 0; k < sym_count; k++) begin
			assert (hc_o[k] == exp_hc[k]) else report_mismatch($sformatf(
				"%s: HC%0d is %b, expected %b", label, k + 1, hc_o[k], exp_hc[k]));
			assert (m_o[k] == exp_m[k]) else report_mismatch($sformatf(
				"%s: M%0d is %b, expected %b", label, k + 1, m_o[k], exp_m[k]));
		end
	endtask

	task automatic check_prefix_free(string label);
		int len [sym_count];
		int kraft;
		kraft = 0;
		for (int k = 0; k < sym_count; k++) begin
			len[k] = $countones(m_o[k]);
			kraft += 1 << (8 - len[k]);
		end
		assert (kraft == 256) else report_mismatch($sformatf(
			"%s: Kraft sum is %0d/256, expected 1", label, kraft));
		for (int i = 0; i < sym_count; i++)
			for (int j = 0; j < sym_count; j++)
				if (i != j && len[i] <= len[j])
					assert ((hc_o[j] >> (len[j] - len[i])) != hc_o[i]) else report_mismatch(
						$sformatf("%s: HC%0d is a prefix of HC%0d", label, i + 1, j + 1));
	endtask

	// pulse counts cleared by every reset
	always @(negedge clk) begin
		if (reset) begin
			cnt_pulses  = 0;
			code_pulses = 0;
		end else begin
			if (CNT_valid) cnt_pulses++;
			if (code_valid) begin
				code_pulses++;
				assert (cnt_pulses == 1) else report_mismatch(
					"code_valid without exactly one CNT_valid before it");
			end
		end
	end

	always @(negedge clk)
		if (uut.u_assertions.fired) abort_run("a protocol assertion bound to the DUT failed");

	// ====================
	// one case runs from a fresh reset through both pulses
	task automatic run_case(string label);
		@(posedge clk);
		reset      <= 1'b1;
		gray_valid <= 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		build_reference();
		foreach (stream[i]) begin
			@(posedge clk);
			gray_valid <= 1'b1;
			gray_data  <= stream[i];
		end
		@(posedge clk);
		gray_valid <= 1'b0;
		gray_data  <= '0;
		do @(negedge clk); while (!CNT_valid);
		check_counts(label);
		do @(negedge clk); while (!code_valid);
		check_prefix_free(label);
		check_codes(label);
		repeat (4) @(negedge clk); // no late or repeated pulses
		assert (cnt_pulses == 1 && code_pulses == 1) else report_mismatch($sformatf(
			"%s: saw %0d CNT_valid and %0d code_valid pulses, expected one each",
			label, cnt_pulses, code_pulses));
	endtask

	initial begin
		reset      = 1'b1;
		gray_valid = 1'b0;
		gray_data  = '0;
		random_stream(120, 10);
		run_case("mixed stream");
		random_stream(max_len, 8);
		run_case("long mixed stream");
		distinct_counts();
		run_case("random distinct counts");
		stream_from_counts('{1, 2, 4, 8, 16, 32});
		run_case("skewed distinct counts");
		stream_from_counts('{10, 10, 10, 10, 10, 10});
		run_case("all counts equal");
		stream_from_counts('{4, 4, 7, 7, 2, 2});
		run_case("paired ties");
		stream_from_counts('{0, 5, 0, 9, 0, 1});
		run_case("absent symbols");
		stream_from_counts('{0, 0, 25, 0, 0, 0});
		run_case("single symbol value");
		random_stream(1 + draw(max_len), 7);
		run_case("random length stream");
		if (uut.u_assertions.fired)
			abort_run("a protocol assertion bound to the DUT failed");
		else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

	initial begin
		#(watchdog_ns);
		abort_run($sformatf("timeout: cases still running after %0d ns", watchdog_ns));
	end

endmodule

// ==== tb.f ====
source/huffman_pkg.sv
source/symbol_histogram.sv
source/huffman_control.sv
source/node_list.sv
source/code_builder.sv
source/huffman.sv
tests/huffman_assertions.sv
tests/huffman_tb.sv

// ==== Bender.yml ====
package:
  name: huffman

sources:
  - files:
      - source/huffman_pkg.sv
      - source/symbol_histogram.sv
      - source/huffman_control.sv
      - source/node_list.sv
      - source/code_builder.sv
      - source/huffman.sv
  - target: test
    files:
      - tests/huffman_assertions.sv
      - tests/huffman_tb.sv
